// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = frame_buffer_tb
FILELIST = files.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir obj_dir -o sim
	-./obj_dir/sim 2>&1 | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== files.f ====
+incdir+src
src/fb_pkg.sv
src/pixel_intake.sv
src/fb_port_arbiter.sv
src/sram_interface.sv
src/read_return.sv
src/frame_buffer_top.sv
verification/zbt_sram_model.sv
verification/frame_buffer_asserts.sv
verification/frame_buffer_tb.sv

// ==== src/fb_defines.svh ====
//--------------------------------------------------
// Frame buffer parameters shared by the RTL.
// Include wherever resolution, latency or bus widths are needed.
//--------------------------------------------------
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// View area in pixels
`define FB_X_RES 800
`define FB_Y_RES 600

// Cycles from a sampled read request to request_ready
`define FB_SRAM_DELAY 5

// SRAM address is {x[9:0], y[9:0]}
`define FB_ADDR_W 20

// SRAM word, top bit unused and written as zero
`define FB_DATA_W 17

// Pixel as seen by the pipeline
`define FB_PIX_W 16

`endif

// ==== src/fb_pkg.sv ====
//--------------------------------------------------
// Types shared between the frame buffer port blocks.
// Modules refer to these by scoped name or wildcard import.
//--------------------------------------------------
`include "fb_defines.svh"

package fb_pkg;

    // Pixel write candidate from one of the input sources
    typedef struct packed {
        logic                  valid;
        logic [`FB_ADDR_W-1:0] addr;
        logic [`FB_PIX_W-1:0]  pixel;
    } pixel_write_t;

    // One command toward the SRAM pins
    // Reads are every cycle with we low
    typedef struct packed {
        logic                  we;
        logic [`FB_ADDR_W-1:0] addr;
        logic [`FB_DATA_W-1:0] wdata;
    } sram_cmd_t;

    // Side information carried alongside a read
    typedef struct packed {
        logic issued;
        // Blank pixel is returned instead of SRAM data
        logic oob;
    } read_tag_t;

    // Operation granted the SRAM port in a cycle
    typedef enum logic [1:0] {
        OP_IDLE      = 2'd0,
        OP_READ      = 2'd1,
        OP_ADC_WRITE = 2'd2,
        OP_SPI_WRITE = 2'd3
    } port_op_e;

endpackage

// ==== src/fb_port_arbiter.sv ====
//--------------------------------------------------
// Shares the single SRAM port between reads, ADC writes and SPI writes.
// Priority is read, then ADC, then SPI. Registers one command and
// one read tag per cycle.
//--------------------------------------------------
`timescale 1ns/10ps
`include "fb_defines.svh"

module fb_port_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  request_active,
    input  logic signed [11:0]    request_x,
    input  logic signed [11:0]    request_y,
    input  logic                  adc_ready,
    input  fb_pkg::pixel_write_t  adc_write,
    input  fb_pkg::pixel_write_t  spi_write,
    output logic                  adc_grant,
    output fb_pkg::sram_cmd_t     sram_cmd,
    output fb_pkg::read_tag_t     read_tag
);

    import fb_pkg::*;

    port_op_e   port_op;
    logic       read_oob;
    sram_cmd_t  cmd_next;
    read_tag_t  tag_next;

    // Raw ready decides the slot, so a dropped ADC pixel still blocks SPI
    always_comb begin
        if (request_active) begin
            port_op = OP_READ;
        end else if (adc_ready) begin
            port_op = OP_ADC_WRITE;
        end else if (spi_write.valid) begin
            port_op = OP_SPI_WRITE;
        end else begin
            port_op = OP_IDLE;
        end
    end

    // FIFO is held back while a read owns the port
    assign adc_grant = (port_op == OP_ADC_WRITE);

    // Signed compare catches negative coordinates
    assign read_oob = (request_x < 0) || (request_y < 0) ||
                      (request_x >= `FB_X_RES) || (request_y >= `FB_Y_RES);

    always_comb begin
        // Default is a read at the request address
        cmd_next.we    = 1'b0;
        cmd_next.addr  = {request_x[9:0], request_y[9:0]};
        cmd_next.wdata = '0;
        case (port_op)
            OP_ADC_WRITE: begin
                cmd_next.we    = adc_write.valid;
                cmd_next.addr  = adc_write.addr;
                cmd_next.wdata = {1'b0, adc_write.pixel};
            end
            OP_SPI_WRITE: begin
                cmd_next.we    = 1'b1;
                cmd_next.addr  = spi_write.addr;
                cmd_next.wdata = {1'b0, spi_write.pixel};
            end
            default: begin
                cmd_next.we = 1'b0;
            end
        endcase
    end

    always_comb begin
        tag_next.issued = (port_op == OP_READ);
        tag_next.oob    = (port_op == OP_READ) && read_oob;
    end

    // Address and data follow the selection every cycle
    always_ff @(posedge clk) begin
        sram_cmd.addr  <= cmd_next.addr;
        sram_cmd.wdata <= cmd_next.wdata;
        if (rst) begin
            sram_cmd.we <= 1'b0;
            read_tag    <= '0;
        end else begin
            sram_cmd.we <= cmd_next.we;
            read_tag    <= tag_next;
        end
    end

endmodule

// ==== src/frame_buffer_top.sv ====
//--------------------------------------------------
// Frame buffer port top level.
// Connects pixel intake, arbiter, SRAM pins and read return.
//--------------------------------------------------
`timescale 1ns/10ps
`include "fb_defines.svh"

module frame_buffer_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frozen,
    // Pipeline read requests
    input  logic                   request_active,
    input  logic signed [11:0]     request_x,
    input  logic signed [11:0]     request_y,
    output logic [`FB_PIX_W-1:0]   request_data,
    output logic                   request_ready,
    // ADC FIFO head
    input  logic [37:0]            adc_pixel_data,
    input  logic                   adc_pixel_ready,
    output logic                   adc_pixel_read,
    // SPI pixel input
    input  logic                   spi_active,
    input  logic [`FB_PIX_W-1:0]   spi_pixel_in,
    input  logic signed [11:0]     spi_pixel_x,
    input  logic signed [11:0]     spi_pixel_y,
    // SRAM pins
    output logic [`FB_ADDR_W-1:0]  hw_sram_addr,
    inout  wire  [`FB_DATA_W-1:0]  hw_sram_data,
    output logic                   hw_sram_advload,
    output logic                   hw_sram_write_enable,
    output logic                   hw_sram_chip_enable,
    output logic                   hw_sram_oe,
    output logic                   hw_sram_clk_enable,
    output logic                   hw_sram_clk
);

    import fb_pkg::*;

    pixel_write_t           adc_write;
    pixel_write_t           spi_write;
    sram_cmd_t              sram_cmd;
    read_tag_t              read_tag;
    logic                   adc_grant;
    logic [`FB_DATA_W-1:0]  read_word;

    pixel_intake intake0 (
        .clk             (clk),
        .rst             (rst),
        .frozen          (frozen),
        .adc_pixel_data  (adc_pixel_data),
        .adc_pixel_ready (adc_pixel_ready),
        .adc_grant       (adc_grant),
        .spi_active      (spi_active),
        .spi_pixel_in    (spi_pixel_in),
        .spi_pixel_x     (spi_pixel_x),
        .spi_pixel_y     (spi_pixel_y),
        .adc_pixel_read  (adc_pixel_read),
        .adc_write       (adc_write),
        .spi_write       (spi_write)
    );

    fb_port_arbiter arb0 (
        .clk            (clk),
        .rst            (rst),
        .request_active (request_active),
        .request_x      (request_x),
        .request_y      (request_y),
        .adc_ready      (adc_pixel_ready),
        .adc_write      (adc_write),
        .spi_write      (spi_write),
        .adc_grant      (adc_grant),
        .sram_cmd       (sram_cmd),
        .read_tag       (read_tag)
    );

    sram_interface sram0 (
        .clk                  (clk),
        .rst                  (rst),
        .sram_cmd             (sram_cmd),
        .read_word            (read_word),
        .hw_sram_addr         (hw_sram_addr),
        .hw_sram_data         (hw_sram_data),
        .hw_sram_advload      (hw_sram_advload),
        .hw_sram_write_enable (hw_sram_write_enable),
        .hw_sram_chip_enable  (hw_sram_chip_enable),
        .hw_sram_oe           (hw_sram_oe),
        .hw_sram_clk_enable   (hw_sram_clk_enable),
        .hw_sram_clk          (hw_sram_clk)
    );

    read_return ret0 (
        .clk           (clk),
        .rst           (rst),
        .read_tag      (read_tag),
        .read_word     (read_word),
        .request_data  (request_data),
        .request_ready (request_ready)
    );

endmodule

// ==== src/pixel_intake.sv ====
//--------------------------------------------------
// Input side of the frame buffer port.
// Decodes ADC FIFO words and SPI pixels into write candidates
// and pops the ADC FIFO when the arbiter grants it.
//--------------------------------------------------
`timescale 1ns/10ps
`include "fb_defines.svh"

module pixel_intake (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       frozen,
    input  logic [37:0]                adc_pixel_data,
    input  logic                       adc_pixel_ready,
    input  logic                       adc_grant,
    input  logic                       spi_active,
    input  logic [`FB_PIX_W-1:0]       spi_pixel_in,
    input  logic signed [11:0]         spi_pixel_x,
    input  logic signed [11:0]         spi_pixel_y,
    output logic                       adc_pixel_read,
    output fb_pkg::pixel_write_t       adc_write,
    output fb_pkg::pixel_write_t       spi_write
);

    // ADC word layout: x[37:27], y[26:16], pixel[15:0]
    logic [10:0]           adc_x;
    logic [10:0]           adc_y;
    logic [`FB_PIX_W-1:0]  adc_pix;
    logic                  adc_in_view;

    assign adc_x   = adc_pixel_data[37:27];
    assign adc_y   = adc_pixel_data[26:16];
    assign adc_pix = adc_pixel_data[15:0];

    // Unsigned coordinates so only the upper bound matters
    assign adc_in_view = (adc_x < `FB_X_RES) && (adc_y < `FB_Y_RES);

    // Dropped pixels still reach the arbiter as ready but not valid
    assign adc_write.valid = adc_pixel_ready && adc_in_view && !frozen;
    assign adc_write.addr  = {adc_x[9:0], adc_y[9:0]};
    assign adc_write.pixel = adc_pix;

    // SPI pixel has no bounds check, low bits wrap into the address
    assign spi_write.valid = spi_active;
    assign spi_write.addr  = {spi_pixel_x[9:0], spi_pixel_y[9:0]};
    assign spi_write.pixel = spi_pixel_in;

    // Pop whenever granted, written or not
    assign adc_pixel_read = adc_grant;

endmodule

// ==== src/read_return.sv ====
//--------------------------------------------------
// Output side of the frame buffer port.
// Delays read tags to meet the SRAM data and returns the pixel,
// or zero for reads outside the view.
//--------------------------------------------------
`timescale 1ns/10ps
`include "fb_defines.svh"

module read_return (
    input  logic                   clk,
    input  logic                   rst,
    input  fb_pkg::read_tag_t      read_tag,
    input  logic [`FB_DATA_W-1:0]  read_word,
    output logic [`FB_PIX_W-1:0]   request_data,
    output logic                   request_ready
);

    import fb_pkg::*;

    localparam int TAG_DEPTH = `FB_SRAM_DELAY - 1;

    // Arbiter stage plus this line plus the output register
    read_tag_t tag_line [0:TAG_DEPTH-1];
    read_tag_t tag_tail;

    assign tag_tail = tag_line[TAG_DEPTH-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TAG_DEPTH; i++) begin
                tag_line[i] <= '0;
            end
            request_ready <= 1'b0;
        end else begin
            tag_line[0] <= read_tag;
            for (int i = 1; i < TAG_DEPTH; i++) begin
                tag_line[i] <= tag_line[i-1];
            end
            request_ready <= tag_tail.issued;
        end
    end

    // Bit 16 of the word is dropped
    always_ff @(posedge clk) begin
        if (tag_tail.oob) begin
            request_data <= '0;
        end else begin
            request_data <= read_word[`FB_PIX_W-1:0];
        end
    end

endmodule

// ==== src/sram_interface.sv ====
//--------------------------------------------------
// Pin side of a pipelined ZBT SRAM.
// Control pins are active low. Write data follows its address
// by two cycles and read data is captured in the same slot.
//--------------------------------------------------
`timescale 1ns/10ps
`include "fb_defines.svh"

module sram_interface (
    input  logic                   clk,
    input  logic                   rst,
    input  fb_pkg::sram_cmd_t      sram_cmd,
    output logic [`FB_DATA_W-1:0]  read_word,
    output logic [`FB_ADDR_W-1:0]  hw_sram_addr,
    inout  wire  [`FB_DATA_W-1:0]  hw_sram_data,
    output logic                   hw_sram_advload,
    output logic                   hw_sram_write_enable,
    output logic                   hw_sram_chip_enable,
    output logic                   hw_sram_oe,
    output logic                   hw_sram_clk_enable,
    output logic                   hw_sram_clk
);

    logic                  we_q;
    logic                  rd_q;
    // Index 1 is the data phase, two cycles after the address
    logic [1:0]            wr_phase;
    logic [1:0]            rd_phase;
    logic [`FB_DATA_W-1:0] wdata_pipe [0:2];

    // Address goes out with the command
    always_ff @(posedge clk) begin
        hw_sram_addr  <= sram_cmd.addr;
        wdata_pipe[0] <= sram_cmd.wdata;
        wdata_pipe[1] <= wdata_pipe[0];
        wdata_pipe[2] <= wdata_pipe[1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            we_q     <= 1'b0;
            rd_q     <= 1'b0;
            wr_phase <= '0;
            rd_phase <= '0;
        end else begin
            we_q     <= sram_cmd.we;
            rd_q     <= !sram_cmd.we;
            wr_phase <= {wr_phase[0], we_q};
            rd_phase <= {rd_phase[0], rd_q};
        end
    end

    // Every cycle loads a new address
    assign hw_sram_advload      = 1'b0;
    assign hw_sram_chip_enable  = 1'b0;
    assign hw_sram_clk_enable   = 1'b0;
    assign hw_sram_write_enable = !we_q;
    assign hw_sram_clk          = clk;

    // SRAM drives only in a read data phase
    assign hw_sram_oe = !rd_phase[1];

    // Bus owned by the controller only in a write data phase
    assign hw_sram_data = wr_phase[1] ? wdata_pipe[2] : 'z;

    // Free running capture, the tag line picks the right word
    always_ff @(posedge clk) begin
        read_word <= hw_sram_data;
    end

endmodule

// ==== verification/frame_buffer_asserts.sv ====
//--------------------------------------------------
// Concurrent checks on the SRAM port arbiter.
// Bound into every fb_port_arbiter instance.
//--------------------------------------------------
`timescale 1ns/10ps

module frame_buffer_asserts (
    input logic              clk,
    input logic              rst,
    input logic              request_active,
    input logic              adc_grant,
    input fb_pkg::port_op_e  port_op,
    input fb_pkg::sram_cmd_t sram_cmd,
    input fb_pkg::read_tag_t read_tag
);

    import fb_pkg::*;

    // Registered command and tag never claim the port together
    one_op_per_cycle: assert property (@(posedge clk) disable iff (rst)
        !(sram_cmd.we && read_tag.issued))
        else $error("write command and read tag issued in the same cycle");

    // ADC FIFO is never popped under a read
    no_pop_on_read: assert property (@(posedge clk) disable iff (rst)
        request_active |-> !adc_grant)
        else $error("ADC pop granted during a read");

    // Read cycle issues a read command
    no_we_on_read: assert property (@(posedge clk) disable iff (rst)
        (port_op == OP_READ) |=> !sram_cmd.we)
        else $error("write enable set for a read cycle");

    // First stage of the fixed read latency
    tag_follows_read: assert property (@(posedge clk) disable iff (rst)
        request_active |=> read_tag.issued)
        else $error("read tag missing one cycle after request");

    no_tag_without_read: assert property (@(posedge clk) disable iff (rst)
        !request_active |=> !read_tag.issued)
        else $error("read tag issued without a request");

endmodule

bind fb_port_arbiter frame_buffer_asserts asserts0 (
    .clk            (clk),
    .rst            (rst),
    .request_active (request_active),
    .adc_grant      (adc_grant),
    .port_op        (port_op),
    .sram_cmd       (sram_cmd),
    .read_tag       (read_tag)
);

// ==== verification/frame_buffer_tb.sv ====
//--------------------------------------------------
// Testbench for the frame buffer port.
// Applies a stimulus table one row per cycle, keeps a reference
// frame and checks pops and read results against it.
//--------------------------------------------------
`timescale 1ns/10ps
`include "fb_defines.svh"

module frame_buffer_tb;

    localparam time CLK_PERIOD = 100ns;

    // One cycle of stimulus with the expected ADC pop
    typedef struct packed {
        logic               req;
        logic signed [11:0] rx;
        logic signed [11:0] ry;
        logic               adc;
        logic [10:0]        ax;
        logic [10:0]        ay;
        logic               spi;
        logic signed [11:0] sx;
        logic signed [11:0] sy;
        logic               frz;
        logic               pop;
    } row_t;

    // Expected read result and the edge its request was sampled
    typedef struct packed {
        int unsigned edge_n;
        logic [15:0] data;
    } expect_t;

    logic               clk;
    logic               rst;
    logic               frozen;
    logic               request_active;
    logic signed [11:0] request_x;
    logic signed [11:0] request_y;
    logic [15:0]        request_data;
    logic               request_ready;
    logic [37:0]        adc_pixel_data;
    logic               adc_pixel_ready;
    logic               adc_pixel_read;
    logic               spi_active;
    logic [15:0]        spi_pixel_in;
    logic signed [11:0] spi_pixel_x;
    logic signed [11:0] spi_pixel_y;
    logic [19:0]        hw_sram_addr;
    wire  [16:0]        hw_sram_data;
    logic               hw_sram_advload;
    logic               hw_sram_write_enable;
    logic               hw_sram_chip_enable;
    logic               hw_sram_oe;
    logic               hw_sram_clk_enable;
    logic               hw_sram_clk;

    row_t        rows [$];
    expect_t     expq [$];
    logic [15:0] frame [logic [19:0]];
    integer      seed;
    int unsigned edge_count;
    logic        table_built;

    frame_buffer_top dut0 (.*);

    zbt_sram_model sram_model0 (
        .clk          (hw_sram_clk),
        .addr         (hw_sram_addr),
        .data         (hw_sram_data),
        .advload      (hw_sram_advload),
        .write_enable (hw_sram_write_enable),
        .chip_enable  (hw_sram_chip_enable),
        .oe           (hw_sram_oe),
        .clk_enable   (hw_sram_clk_enable)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic add_row(input logic req, input int rx, input int ry,
                           input logic adc, input int ax, input int ay,
                           input logic spi, input int sx, input int sy,
                           input logic frz, input logic pop);
        row_t r;
        r.req = req;
        r.rx  = rx[11:0];
        r.ry  = ry[11:0];
        r.adc = adc;
        r.ax  = ax[10:0];
        r.ay  = ay[10:0];
        r.spi = spi;
        r.sx  = sx[11:0];
        r.sy  = sy[11:0];
        r.frz = frz;
        r.pop = pop;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // req rx ry | adc ax ay | spi sx sy | frozen | expected pop
        add_row(0,     0,     0,  1,  799,  599,  0,   0,   0,  0, 1);
        add_row(0,     0,     0,  1,   10,   20,  0,   0,   0,  0, 1);
        add_row(0,     0,     0,  1,   11,   20,  0,   0,   0,  0, 1);
        add_row(1,    10,    20,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(1,    11,    20,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(1,    10,    20,  0,    0,    0,  0,   0,   0,  0, 0);
        // SPI fills locations just past the view edges
        add_row(0,     0,     0,  0,    0,    0,  1, 800,  20,  0, 0);
        add_row(0,     0,     0,  0,    0,    0,  1,  20, 600,  0, 0);
        // Out of view reads, each aliasing a written location
        add_row(1, -1014,    20,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(1,    10, -1004,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(1,   800,    20,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(1,    20,   600,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(1,  1034,    20,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(1,   799,   599,  0,    0,    0,  0,   0,   0,  0, 0);
        // Frozen and out of view ADC pixels are dropped
        add_row(0,     0,     0,  1,   10,   20,  0,   0,   0,  1, 1);
        add_row(0,     0,     0,  1,   11,   20,  0,   0,   0,  0, 1);
        add_row(0,     0,     0,  1, 1034,   20,  0,   0,   0,  0, 1);
        add_row(0,     0,     0,  1,   10, 1044,  0,   0,   0,  0, 1);
        add_row(1,    10,    20,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(1,    11,    20,  0,    0,    0,  0,   0,   0,  0, 0);
        // ADC held back by a read
        add_row(1,    12,    30,  1,   12,   30,  0,   0,   0,  0, 0);
        add_row(0,     0,     0,  1,   12,   30,  0,   0,   0,  0, 1);
        add_row(1,    12,    30,  0,    0,    0,  0,   0,   0,  0, 0);
        // SPI loses to a read, then to an ADC pixel
        add_row(1,     1,     1,  0,    0,    0,  1,  40,  50,  0, 0);
        add_row(0,     0,     0,  1,   13,   30,  1,  40,  50,  0, 1);
        add_row(1,    40,    50,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(0,     0,     0,  0,    0,    0,  1,  41,  50,  0, 0);
        add_row(1,    41,    50,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(0,     0,     0,  0,    0,    0,  1,  40,  50,  0, 0);
        add_row(1,    40,    50,  0,    0,    0,  0,   0,   0,  0, 0);
        add_row(1,    13,    30,  0,    0,    0,  0,   0,   0,  0, 0);
    endtask

    // Reference frame update by priority and bounds rules
    task automatic apply_rules(input row_t r, input logic [15:0] adc_pix,
                               input logic [15:0] spi_pix);
        logic signed [11:0] x;
        logic signed [11:0] y;
        logic [19:0]        a;
        expect_t            e;
        x = r.rx;
        y = r.ry;
        if (r.req) begin
            a = {x[9:0], y[9:0]};
            e.edge_n = edge_count + 1;
            if (x < 0 || y < 0 || x >= `FB_X_RES || y >= `FB_Y_RES) begin
                e.data = '0;
            end else if (frame.exists(a)) begin
                e.data = frame[a];
            end else begin
                e.data = '0;
            end
            expq.push_back(e);
        end else if (r.adc) begin
            // Popped in any case, written only in view and not frozen
            if (r.ax < `FB_X_RES && r.ay < `FB_Y_RES && !r.frz) begin
                frame[{r.ax[9:0], r.ay[9:0]}] = adc_pix;
            end
        end else if (r.spi) begin
            frame[{r.sx[9:0], r.sy[9:0]}] = spi_pix;
        end
    endtask

    task automatic drive_row(input row_t r);
        logic [15:0] adc_pix;
        logic [15:0] spi_pix;
        adc_pix         = $random(seed);
        spi_pix         = $random(seed);
        request_active  = r.req;
        request_x       = r.rx;
        request_y       = r.ry;
        adc_pixel_ready = r.adc;
        adc_pixel_data  = {r.ax, r.ay, adc_pix};
        spi_active      = r.spi;
        spi_pixel_in    = spi_pix;
        spi_pixel_x     = r.sx;
        spi_pixel_y     = r.sy;
        frozen          = r.frz;
        apply_rules(r, adc_pix, spi_pix);
    endtask

    // Runs at a falling edge, before the next row is driven
    task automatic check_outputs(input logic exp_pop);
        expect_t head;
        assert (adc_pixel_read == exp_pop) else begin
            report_failure($sformatf("FAIL adc_pixel_read expected %h got %h",
                                     exp_pop, adc_pixel_read));
        end
        if (request_ready) begin
            assert (expq.size() > 0) else begin
                report_failure("request_ready went high with no read outstanding");
            end
            head = expq.pop_front();
            assert (head.edge_n + `FB_SRAM_DELAY == edge_count) else begin
                report_failure($sformatf("FAIL request_ready edge expected %h got %h",
                                         head.edge_n + `FB_SRAM_DELAY, edge_count));
            end
            assert (request_data == head.data) else begin
                report_failure($sformatf("FAIL request_data expected %h got %h",
                                         head.data, request_data));
            end
        end else if (expq.size() > 0) begin
            assert (expq[0].edge_n + `FB_SRAM_DELAY > edge_count) else begin
                report_failure("read result did not arrive on time");
            end
        end
    endtask

    initial begin
        row_t idle;
        seed            = 32'he734_8b69;
        edge_count      = 0;
        table_built     = 1'b0;
        idle            = '0;
        rst             = 1'b1;
        frozen          = 1'b0;
        request_active  = 1'b0;
        request_x       = '0;
        request_y       = '0;
        adc_pixel_data  = '0;
        adc_pixel_ready = 1'b0;
        spi_active      = 1'b0;
        spi_pixel_in    = '0;
        spi_pixel_x     = '0;
        spi_pixel_y     = '0;
        build_table();
        table_built = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            drive_row(rows[i]);
            @(negedge clk);
            check_outputs(rows[i].pop);
        end
        // Drain reads still in flight
        while (expq.size() > 0) begin
            drive_row(idle);
            @(negedge clk);
            check_outputs(1'b0);
        end
        $display("TEST PASS");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        time limit;
        wait (table_built);
        limit = (rows.size() + 20) * CLK_PERIOD;
        #(limit);
        report_failure("Timeout, the test did not finish in time");
    end

endmodule

// ==== verification/zbt_sram_model.sv ====
//--------------------------------------------------
// Behavioral pipelined ZBT SRAM for simulation.
// Address and control sampled at edge A, data phase at edge A+2.
// Unwritten locations read as zero.
//--------------------------------------------------
`timescale 1ns/10ps

module zbt_sram_model (
    input  logic        clk,
    input  logic [19:0] addr,
    inout  wire  [16:0] data,
    input  logic        advload,
    input  logic        write_enable,
    input  logic        chip_enable,
    input  logic        oe,
    input  logic        clk_enable
);

    // One access moving through the SRAM pipeline
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [19:0] addr;
    } slot_t;

    logic [16:0] mem [logic [19:0]];
    slot_t       stage1 = '0;
    slot_t       stage2 = '0;
    logic [16:0] rd_data = '0;

    always @(posedge clk) begin
        if (!clk_enable) begin
            // Write data arrives two edges after its address
            if (stage2.valid && stage2.we) begin
                mem[stage2.addr] = data;
            end
            // Read word fetched one edge early, after any write above
            if (stage1.valid && !stage1.we) begin
                if (mem.exists(stage1.addr)) begin
                    rd_data <= mem[stage1.addr];
                end else begin
                    rd_data <= '0;
                end
            end
            stage2       <= stage1;
            stage1.valid <= !chip_enable && !advload;
            stage1.we    <= !write_enable;
            stage1.addr  <= addr;
        end
    end

    // Drive only in a read data phase with output enable low
    assign data = (!oe && stage2.valid && !stage2.we) ? rd_data : 'z;

endmodule
